// ==== all.f ====
src/rsa_pkg.sv
src/rsa_mont_mult.sv
src/rsa_mod_prod.sv
src/rsa_core.sv
src/rsa_avm_wrapper.sv
sim/tb_rsa.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal --top-module tb_rsa -o tb_rsa -f all.f \
    && ./obj_dir/tb_rsa | tee /dev/stderr | grep -qx "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/rsa_patterns.hex ====
// one 256-bit word per line: modulus n, exponent d,
// then ciphertext and expected plaintext for each message
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
9d3a5c17e2b846f00c71a94d3e6b2f851a7c3e90d4b62f1853e9a7c1d02b684b
0000000000000000000000000000000000000000000000000000000000000002
0000000000000000000000000000000000000000000008000000000000000000
0000000000000000000000000000000000000000000000000000000000000080
0000000000000000000000000000000000000000000000000000000000002000
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe
0000000000000100000000000000000000000000000000000000000000000000
0000000000000000000000000100000000000000000000000000000000000000

// ==== sim/tb_rsa.sv ====
`timescale 1ns/1ps

module tb_rsa;

    localparam int msg_count   = 4;
    // one exponentiation is about 66.6k cycles, plus polling and key load
    localparam int cycle_limit = msg_count * 70000 + 20000;

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata = 32'd0;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b1;

    rsa_pkg::rsa_word_t pat_mem [0:2*msg_count+1];   // n, d, then cipher/plain pairs
    logic [7:0] rx_queue [$];
    logic [31:0] rng_state = 32'h13a0_2843;

    // serial port model state
    logic rx_ok = 1'b0;
    logic tx_ok = 1'b0;
    logic stat_rx_seen = 1'b0;     // last completed status read had rx ready
    logic stat_tx_seen = 1'b0;
    logic hold_valid = 1'b0;
    logic [4:0]  hold_addr;
    logic        hold_rd;
    logic        hold_wr;
    logic [31:0] hold_wdata;
    logic [31:0] stat;
    logic prev_rst = 1'b1;

    int cycle_cnt = 0;
    int msg_idx   = 0;
    int byte_idx  = 0;
    int tx_total  = 0;
    rsa_pkg::rsa_word_t got_word = '0;

    rsa_avm_wrapper uut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    initial begin
        avm_clk = 1'b0;
        forever #4 avm_clk = ~avm_clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic coin_flip();
        rng_state = lcg_step(rng_state);
        return rng_state[31];   // top bit, low bits of an lcg are weak
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s expected %02h actual %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input rsa_pkg::rsa_word_t exp,
                              input rsa_pkg::rsa_word_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s expected %064h actual %064h",
                                    name, exp, act));
    endtask

    // one completed write to the tx register
    task automatic record_tx_byte(input logic [7:0] data);
        rsa_pkg::rsa_word_t plain;
        if (msg_idx >= msg_count) begin
            stop_on_error("TX write after the last message was complete");
        end else begin
            plain = pat_mem[3 + 2 * msg_idx];
            check_byte($sformatf("msg %0d byte %0d", msg_idx, byte_idx),
                       plain[(rsa_pkg::rsa_out_bytes - 1 - byte_idx) * 8 +: 8], data);
            got_word = {got_word[rsa_pkg::rsa_width-9:0], data};
            byte_idx++;
            tx_total++;
            if (byte_idx == rsa_pkg::rsa_out_bytes) begin
                check_word($sformatf("msg %0d", msg_idx),
                           {8'd0, plain[rsa_pkg::rsa_width-9:0]}, got_word);
                // key must not be read again, only one ciphertext per message
                if (rx_queue.size() != rsa_pkg::rsa_bytes * (msg_count - 1 - msg_idx))
                    stop_on_error($sformatf("RX bytes consumed do not match after message %0d",
                                            msg_idx));
                got_word = '0;
                byte_idx = 0;
                msg_idx++;
            end
        end
    endtask

    // serial port slave with random waitrequest and ready flags
    always @(posedge avm_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            stop_on_error($sformatf("timeout after %0d cycles with %0d of %0d messages done",
                                    cycle_cnt, msg_idx, msg_count));
        // first edge may still see the outputs before reset took hold
        if ((avm_rst || prev_rst) && cycle_cnt > 1) begin
            if (avm_read !== 1'b0 || avm_write !== 1'b0 || avm_address !== rsa_pkg::addr_status)
                stop_on_error("bus not idle with status address during or right after reset");
        end
        prev_rst = avm_rst;

        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
            avm_readdata    <= 32'd0;
        end else begin
            if (hold_valid && (avm_address !== hold_addr || avm_read !== hold_rd ||
                               avm_write !== hold_wr || avm_writedata !== hold_wdata))
                stop_on_error("bus signals changed while waitrequest was high");
            hold_valid = (avm_read || avm_write) && avm_waitrequest;
            hold_addr  = avm_address;
            hold_rd    = avm_read;
            hold_wr    = avm_write;
            hold_wdata = avm_writedata;

            if (avm_read && avm_write)
                stop_on_error("read and write asserted together");
            if (avm_read && avm_address == rsa_pkg::addr_rx && !(rx_ok && stat_rx_seen))
                stop_on_error("RX read issued while the port had no RX data ready");
            if (avm_write && !(avm_address == rsa_pkg::addr_tx && stat_tx_seen))
                stop_on_error("TX write issued without a status read showing TX ready");

            if ((avm_read || avm_write) && !avm_waitrequest) begin
                if (avm_read && avm_address == rsa_pkg::addr_status) begin
                    stat_rx_seen = avm_readdata[rsa_pkg::rx_ok_bit];
                    stat_tx_seen = avm_readdata[rsa_pkg::tx_ok_bit];
                    // a flag that was reported set stays until its byte moves
                    if (!rx_ok)
                        rx_ok = (rx_queue.size() > 0) && coin_flip();
                    if (!tx_ok)
                        tx_ok = coin_flip();
                end else if (avm_read && avm_address == rsa_pkg::addr_rx) begin
                    void'(rx_queue.pop_front());
                    rx_ok        = 1'b0;
                    stat_rx_seen = 1'b0;
                end else if (avm_write) begin
                    record_tx_byte(avm_writedata[7:0]);
                    tx_ok        = 1'b0;
                    stat_tx_seen = 1'b0;
                end else begin
                    stop_on_error("read from an address outside the register map");
                end
            end

            stat = 32'd0;
            stat[rsa_pkg::rx_ok_bit] = rx_ok;
            stat[rsa_pkg::tx_ok_bit] = tx_ok;
            avm_waitrequest <= coin_flip();
            if (avm_address == rsa_pkg::addr_status)
                avm_readdata <= stat;
            else if (avm_address == rsa_pkg::addr_rx && rx_queue.size() > 0)
                avm_readdata <= {24'd0, rx_queue[0]};
            else
                avm_readdata <= 32'd0;
        end
    end

    initial begin
        int widx;
        avm_rst = 1'b1;
        $readmemh("sim/rsa_patterns.hex", pat_mem);
        if ($isunknown(pat_mem[2*msg_count+1]))
            stop_on_error("pattern file sim/rsa_patterns.hex missing or too short");
        // n, d, then each ciphertext, msb first
        for (int k = 0; k < msg_count + 2; k++) begin
            widx = (k < 2) ? k : 2 * k - 2;
            for (int i = rsa_pkg::rsa_bytes - 1; i >= 0; i--)
                rx_queue.push_back(pat_mem[widx][i*8 +: 8]);
        end

        repeat (5) @(posedge avm_clk);
        avm_rst <= 1'b0;

        while (msg_idx < msg_count)
            @(posedge avm_clk);
        repeat (50) @(posedge avm_clk);   // time for stray accesses to show

        if (rx_queue.size() == 0 && tx_total == msg_count * rsa_pkg::rsa_out_bytes) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error($sformatf("run ended with %0d RX bytes left and %0d TX bytes written",
                                    rx_queue.size(), tx_total));
        end
    end

endmodule

// ==== src/rsa_avm_wrapper.sv ====
`timescale 1ns/1ps

module rsa_avm_wrapper (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  avm_address,
    output logic        avm_read,
    input  logic [31:0] avm_readdata,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic        avm_waitrequest
);

    rsa_pkg::wrap_state_t state_r, state_w;
    logic       io_work_r, io_work_w;          // 0 is the idle gap, 1 an access on the bus
    logic [4:0] avm_address_r, avm_address_w;
    logic [4:0] byte_cnt_r, byte_cnt_w;
    logic       rsa_start_r, rsa_start_w;

    rsa_pkg::rsa_word_t n_r, n_w;      // modulus
    rsa_pkg::rsa_word_t d_r, d_w;      // private exponent
    rsa_pkg::rsa_word_t enc_r, enc_w;  // ciphertext
    rsa_pkg::rsa_word_t dec_r, dec_w;  // plaintext, shifted out msb first

    rsa_pkg::rsa_word_t rsa_result;
    logic               rsa_finished;

    logic       tx_phase;
    logic       ready_bit;
    logic       last_byte;
    logic [7:0] rx_byte;

    function automatic rsa_pkg::rsa_word_t shift_in(input rsa_pkg::rsa_word_t w,
                                                    input logic [7:0] b);
        return {w[rsa_pkg::rsa_width-9:0], b};
    endfunction

    assign tx_phase  = (state_r == rsa_pkg::s_send_data);
    assign ready_bit = tx_phase ? avm_readdata[rsa_pkg::tx_ok_bit]
                                : avm_readdata[rsa_pkg::rx_ok_bit];
    assign last_byte = tx_phase ? (byte_cnt_r == 5'(rsa_pkg::rsa_out_bytes - 1))
                                : (byte_cnt_r == 5'(rsa_pkg::rsa_bytes - 1));
    assign rx_byte   = avm_readdata[7:0];

    // the address alone tells a tx write from a status or rx read
    assign avm_address   = avm_address_r;
    assign avm_read      = io_work_r && (avm_address_r != rsa_pkg::addr_tx);
    assign avm_write     = io_work_r && (avm_address_r == rsa_pkg::addr_tx);
    assign avm_writedata = {24'd0, dec_r[rsa_pkg::rsa_width-9 -: 8]};

    rsa_core u_core (
        .clk      (avm_clk),
        .rst      (avm_rst),
        .start    (rsa_start_r),
        .a        (enc_r),
        .d        (d_r),
        .n        (n_r),
        .result   (rsa_result),
        .finished (rsa_finished)
    );

    always_comb begin
        state_w       = state_r;
        io_work_w     = io_work_r;
        avm_address_w = avm_address_r;
        byte_cnt_w    = byte_cnt_r;
        rsa_start_w   = 1'b0;
        n_w           = n_r;
        d_w           = d_r;
        enc_w         = enc_r;
        dec_w         = dec_r;

        case (state_r)
            rsa_pkg::s_get_key_n,
            rsa_pkg::s_get_key_d,
            rsa_pkg::s_get_data,
            rsa_pkg::s_send_data: begin
                if (!io_work_r) begin
                    io_work_w = 1'b1;   // launch after the gap cycle
                end else if (!avm_waitrequest) begin
                    io_work_w = 1'b0;
                    if (avm_address_r == rsa_pkg::addr_status) begin
                        // flag clear means poll again
                        if (ready_bit)
                            avm_address_w = tx_phase ? rsa_pkg::addr_tx : rsa_pkg::addr_rx;
                    end else begin
                        avm_address_w = rsa_pkg::addr_status;
                        byte_cnt_w    = last_byte ? 5'd0 : byte_cnt_r + 5'd1;
                        case (state_r)
                            rsa_pkg::s_get_key_n: begin
                                n_w = shift_in(n_r, rx_byte);
                                if (last_byte)
                                    state_w = rsa_pkg::s_get_key_d;
                            end
                            rsa_pkg::s_get_key_d: begin
                                d_w = shift_in(d_r, rx_byte);
                                if (last_byte)
                                    state_w = rsa_pkg::s_get_data;
                            end
                            rsa_pkg::s_get_data: begin
                                enc_w = shift_in(enc_r, rx_byte);
                                if (last_byte)
                                    state_w = rsa_pkg::s_req_calc;
                            end
                            default: begin
                                dec_w = dec_r << 8;
                                // key stays, next ciphertext follows
                                if (last_byte)
                                    state_w = rsa_pkg::s_get_data;
                            end
                        endcase
                    end
                end
            end
            rsa_pkg::s_req_calc: begin
                rsa_start_w = 1'b1;
                state_w     = rsa_pkg::s_wait_calc;
            end
            rsa_pkg::s_wait_calc: begin
                if (rsa_finished) begin
                    dec_w   = rsa_result;
                    state_w = rsa_pkg::s_send_data;
                end
            end
            default: state_w = rsa_pkg::s_get_key_n;
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r       <= rsa_pkg::s_get_key_n;
            io_work_r     <= 1'b0;
            avm_address_r <= rsa_pkg::addr_status;
            byte_cnt_r    <= 5'd0;
            rsa_start_r   <= 1'b0;
        end else begin
            state_r       <= state_w;
            io_work_r     <= io_work_w;
            avm_address_r <= avm_address_w;
            byte_cnt_r    <= byte_cnt_w;
            rsa_start_r   <= rsa_start_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        n_r   <= n_w;
        d_r   <= d_w;
        enc_r <= enc_w;
        dec_r <= dec_w;
    end

endmodule

// ==== src/rsa_core.sv ====
`timescale 1ns/1ps

module rsa_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t d,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t result,
    output logic               finished
);

    typedef enum logic [1:0] {
        c_idle = 2'd0,
        c_prep = 2'd1,
        c_loop = 2'd2,
        c_done = 2'd3
    } core_state_t;

    core_state_t state_r;
    logic [$clog2(rsa_pkg::rsa_width)-1:0] bit_cnt_r;
    logic mstart_r;     // restart of both multipliers after a state update

    rsa_pkg::rsa_word_t d_r;        // exponent, consumed from the lsb
    rsa_pkg::rsa_word_t base_r;     // a^(2^k) in montgomery form
    rsa_pkg::rsa_word_t res_r;      // running result, ordinary form

    logic mp_start;
    logic mp_done;
    logic mul_start;
    logic mul_done;
    logic sq_done;
    logic prep_done;
    logic step_done;

    rsa_pkg::rsa_word_t mp_product;
    rsa_pkg::rsa_word_t mul_product;
    rsa_pkg::rsa_word_t sq_product;
    rsa_pkg::rsa_word_t sq_in;

    assign mp_start  = start && (state_r == c_idle);
    assign prep_done = (state_r == c_prep) && mp_done;
    assign step_done = (state_r == c_loop) && mul_done && sq_done;
    assign mul_start = prep_done || mstart_r;   // first step starts straight off the pre-scale

    // base_r is loaded on the same edge the first square latches its operand
    assign sq_in = prep_done ? mp_product : base_r;

    assign result   = res_r;
    assign finished = (state_r == c_done);

    rsa_mod_prod u_mod_prod (
        .clk     (clk),
        .rst     (rst),
        .start   (mp_start),
        .a       (a),
        .n       (n),
        .product (mp_product),
        .done    (mp_done)
    );

    // res * base, kept only where the exponent bit is set
    rsa_mont_mult u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (res_r),
        .b       (base_r),
        .n       (n),
        .product (mul_product),
        .done    (mul_done)
    );

    rsa_mont_mult u_sq (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (sq_in),
        .b       (base_r),
        .n       (n),
        .product (sq_product),
        .done    (sq_done)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r   <= c_idle;
            bit_cnt_r <= '0;
            mstart_r  <= 1'b0;
        end else begin
            mstart_r <= 1'b0;
            case (state_r)
                c_idle: begin
                    bit_cnt_r <= '0;
                    if (start)
                        state_r <= c_prep;
                end
                c_prep: begin
                    if (mp_done)
                        state_r <= c_loop;
                end
                c_loop: begin
                    if (step_done) begin
                        bit_cnt_r <= bit_cnt_r + 1'b1;
                        if (&bit_cnt_r)
                            state_r <= c_done;  // all 256 bits used
                        else
                            mstart_r <= 1'b1;
                    end
                end
                default: state_r <= c_idle;     // finished lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mp_start) begin
            d_r   <= d;
            res_r <= rsa_pkg::rsa_word_t'(1);
        end
        if (prep_done)
            base_r <= mp_product;
        if (step_done) begin
            base_r <= sq_product;
            d_r    <= d_r >> 1;
            if (d_r[0])
                res_r <= mul_product;
        end
    end

endmodule

// ==== src/rsa_mod_prod.sv ====
`timescale 1ns/1ps

module rsa_mod_prod (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t product,
    output logic               done
);

    logic red_r;        // initial reduction of a
    logic busy_r;       // doubling steps
    logic done_r;
    logic [$clog2(rsa_pkg::rsa_width)-1:0] cnt_r;

    rsa_pkg::rsa_word_t          acc_r;
    rsa_pkg::rsa_word_t          red_sub;
    logic [rsa_pkg::rsa_width:0] dbl;
    logic [rsa_pkg::rsa_width:0] dbl_sub;

    assign red_sub = acc_r - n;
    assign dbl     = {acc_r, 1'b0};
    assign dbl_sub = dbl - {1'b0, n};

    assign product = acc_r;
    assign done    = done_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red_r  <= 1'b0;
            busy_r <= 1'b0;
            done_r <= 1'b0;
            cnt_r  <= '0;
        end else begin
            red_r  <= start;
            done_r <= 1'b0;
            if (red_r) begin
                busy_r <= 1'b1;
                cnt_r  <= '0;
            end else if (busy_r) begin
                cnt_r <= cnt_r + 1'b1;
                if (&cnt_r) begin
                    busy_r <= 1'b0;
                    done_r <= 1'b1;
                end
            end
        end
    end

    // acc doubles mod n once per step, 256 steps give a * 2^256 mod n
    always_ff @(posedge clk) begin
        if (start)
            acc_r <= a;
        else if (red_r)
            acc_r <= (acc_r >= n) ? red_sub : acc_r;
        else if (busy_r)
            acc_r <= (dbl >= {1'b0, n}) ? dbl_sub[rsa_pkg::rsa_width-1:0] : acc_r << 1;
    end

endmodule

// ==== src/rsa_mont_mult.sv ====
`timescale 1ns/1ps

module rsa_mont_mult (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  rsa_pkg::rsa_word_t a,
    input  rsa_pkg::rsa_word_t b,
    input  rsa_pkg::rsa_word_t n,
    output rsa_pkg::rsa_word_t product,
    output logic               done
);

    logic busy_r;       // iterating over the bits of a
    logic fin_r;        // final subtraction cycle
    logic done_r;
    logic [$clog2(rsa_pkg::rsa_width)-1:0] cnt_r;

    rsa_pkg::rsa_word_t a_r;                // shifts right, lsb is the current bit
    logic [rsa_pkg::rsa_width:0]   acc_r;   // stays below 2n
    logic [rsa_pkg::rsa_width+1:0] sum_b;
    logic [rsa_pkg::rsa_width+1:0] sum_n;
    logic [rsa_pkg::rsa_width:0]   fin_sub;
    rsa_pkg::rsa_word_t            prod_r;

    // one radix-2 step: add b if the bit is set, make even with n, halve
    assign sum_b   = {1'b0, acc_r} + {2'b0, b & {rsa_pkg::rsa_width{a_r[0]}}};
    assign sum_n   = sum_b + {2'b0, n & {rsa_pkg::rsa_width{sum_b[0]}}};
    assign fin_sub = acc_r - {1'b0, n};

    assign product = prod_r;
    assign done    = done_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_r <= 1'b0;
            fin_r  <= 1'b0;
            done_r <= 1'b0;
            cnt_r  <= '0;
        end else begin
            fin_r  <= 1'b0;
            done_r <= fin_r;
            if (start) begin
                busy_r <= 1'b1;
                cnt_r  <= '0;
            end else if (busy_r) begin
                cnt_r <= cnt_r + 1'b1;
                if (&cnt_r) begin   // last bit of a
                    busy_r <= 1'b0;
                    fin_r  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_r   <= a;
            acc_r <= '0;
        end else if (busy_r) begin
            a_r   <= a_r >> 1;
            acc_r <= sum_n[rsa_pkg::rsa_width+1:1];
        end
        if (fin_r) begin
            // bring the result from [0, 2n) into [0, n)
            prod_r <= (acc_r >= {1'b0, n}) ? fin_sub[rsa_pkg::rsa_width-1:0]
                                           : acc_r[rsa_pkg::rsa_width-1:0];
        end
    end

endmodule

// ==== src/rsa_pkg.sv ====
package rsa_pkg;

    // key and operand size
    localparam int rsa_width     = 256;
    localparam int rsa_bytes     = rsa_width / 8;
    localparam int rsa_out_bytes = rsa_bytes - 1;   // top byte of the plaintext is not sent

    typedef logic [rsa_width-1:0] rsa_word_t;

    // serial port register map, byte addresses of 32-bit words
    localparam logic [4:0] addr_rx     = 5'd0;
    localparam logic [4:0] addr_tx     = 5'd4;
    localparam logic [4:0] addr_status = 5'd8;

    // status register flags
    localparam int rx_ok_bit = 7;
    localparam int tx_ok_bit = 6;

    // wrapper phases
    typedef enum logic [2:0] {
        s_get_key_n = 3'd0,
        s_get_key_d = 3'd1,
        s_get_data  = 3'd2,
        s_req_calc  = 3'd3,
        s_wait_calc = 3'd4,
        s_send_data = 3'd5
    } wrap_state_t;

endpackage
